//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = procHierBench
FILELIST = tb.f
OBJDIR   = obj_dir

SOURCES  = $(shell cat $(FILELIST))
BINARY   = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(BINARY)

clean:
	rm -rf $(OBJDIR)

//--- logic/coreTypes.sv
`default_nettype none

package coreTypes;

   typedef logic [31:0] wordT;
   typedef logic [31:0] addrT;
   typedef logic [2:0]  regIdxT;
   typedef logic [31:0] instrT;

   typedef enum logic [2:0] {
      opAdd,
      opSub,
      opAnd,
      opOr,
      opXor,
      opPass
   } aluOpT;

   // Decode to execute
   typedef struct packed {
      addrT   pc;
      wordT   a;
      wordT   b;
      wordT   storeData;
      regIdxT rd;
      aluOpT  aluOp;
      logic   regWrite;
      logic   memRead;
      logic   memWrite;
      logic   isBranch;
      logic   branchOnEqual;
      logic   valid;
      addrT   branchTarget;
   } decodedT;

   // Execute to memory with the result doubling as the data address
   typedef struct packed {
      addrT   pc;
      wordT   result;
      wordT   storeData;
      regIdxT rd;
      logic   regWrite;
      logic   memRead;
      logic   memWrite;
      logic   valid;
   } execResultT;

   typedef struct packed {
      logic   valid;
      addrT   pc;
      logic   regWrite;
      regIdxT rd;
      wordT   writeValue;
      logic   memRead;
      logic   memWrite;
      addrT   memAddress;
      wordT   memData;
   } retireT;

   typedef struct packed {
      logic   regWrite;
      regIdxT rd;
      wordT   value;
   } writebackT;

endpackage

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  wire logic                 clk,
   input  wire logic                 rstN,
   input  wire logic                 hold,
   input  wire logic                 flush,
   input  wire coreTypes::addrT      fetchPc,
   input  wire coreTypes::instrT     fetchInstr,
   input  wire logic                 fetchValid,
   input  wire coreTypes::writebackT execBypass,
   input  wire logic                 execIsLoad,
   input  wire coreTypes::writebackT writeback,
   output logic                      loadUseStall,
   output coreTypes::decodedT        decoded
);
   import coreTypes::*;

   localparam logic [6:0] opcodeReg    = 7'b0110011;
   localparam logic [6:0] opcodeImm    = 7'b0010011;
   localparam logic [6:0] opcodeLoad   = 7'b0000011;
   localparam logic [6:0] opcodeStore  = 7'b0100011;
   localparam logic [6:0] opcodeBranch = 7'b1100011;

   wordT       regs [8];
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   regIdxT     rs1;
   regIdxT     rs2;
   wordT       immI;
   wordT       immS;
   wordT       immB;
   wordT       rs1Value;
   wordT       rs2Value;
   logic       usesRs2;
   decodedT    decodedNext;

   // Youngest producer wins
   function automatic wordT pickOperand(regIdxT idx, wordT fileValue,
                                        writebackT fromExec, writebackT fromMem);
      if (idx == '0) begin
         return '0;
      end
      if (fromExec.regWrite && fromExec.rd == idx) begin
         return fromExec.value;
      end
      if (fromMem.regWrite && fromMem.rd == idx) begin
         return fromMem.value;
      end
      return fileValue;
   endfunction

   assign opcode = fetchInstr[6:0];
   assign funct3 = fetchInstr[14:12];
   assign funct7 = fetchInstr[31:25];
   // Upper index bits ignored with only eight registers
   assign rs1    = fetchInstr[17:15];
   assign rs2    = fetchInstr[22:20];

   assign immI = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
   assign immS = {{20{fetchInstr[31]}}, fetchInstr[31:25], fetchInstr[11:7]};
   assign immB = {{19{fetchInstr[31]}}, fetchInstr[31], fetchInstr[7],
                  fetchInstr[30:25], fetchInstr[11:8], 1'b0};

   assign rs1Value = pickOperand(rs1, regs[rs1], execBypass, writeback);
   assign rs2Value = pickOperand(rs2, regs[rs2], execBypass, writeback);

   always_comb begin
      decodedNext              = '0;
      decodedNext.pc           = fetchPc;
      decodedNext.a            = rs1Value;
      decodedNext.b            = rs2Value;
      decodedNext.storeData    = rs2Value;
      decodedNext.rd           = fetchInstr[9:7];
      decodedNext.aluOp        = opPass;
      decodedNext.valid        = fetchValid;
      decodedNext.branchTarget = fetchPc + immB;
      usesRs2                  = 1'b0;
      case (opcode)
         opcodeReg: begin
            usesRs2              = 1'b1;
            decodedNext.regWrite = 1'b1;
            case ({funct7, funct3})
               {7'b0000000, 3'b000}: decodedNext.aluOp = opAdd;
               {7'b0100000, 3'b000}: decodedNext.aluOp = opSub;
               {7'b0000000, 3'b111}: decodedNext.aluOp = opAnd;
               {7'b0000000, 3'b110}: decodedNext.aluOp = opOr;
               {7'b0000000, 3'b100}: decodedNext.aluOp = opXor;
               default: decodedNext.regWrite = 1'b0;
            endcase
         end
         opcodeImm: begin
            if (funct3 == 3'b000) begin
               decodedNext.aluOp    = opAdd;
               decodedNext.b        = immI;
               decodedNext.regWrite = 1'b1;
            end
         end
         opcodeLoad: begin
            if (funct3 == 3'b010) begin
               decodedNext.aluOp    = opAdd;
               decodedNext.b        = immI;
               decodedNext.regWrite = 1'b1;
               decodedNext.memRead  = 1'b1;
            end
         end
         opcodeStore: begin
            usesRs2 = 1'b1;
            if (funct3 == 3'b010) begin
               decodedNext.aluOp    = opAdd;
               decodedNext.b        = immS;
               decodedNext.memWrite = 1'b1;
            end
         end
         opcodeBranch: begin
            usesRs2 = 1'b1;
            if (funct3 == 3'b000 || funct3 == 3'b001) begin
               decodedNext.aluOp         = opSub;
               decodedNext.isBranch      = 1'b1;
               decodedNext.branchOnEqual = (funct3 == 3'b000);
            end
         end
         default: begin
            // Anything else retires as a no-op
            decodedNext.aluOp = opPass;
         end
      endcase
   end

   // Load value is not ready until the memory stage
   assign loadUseStall = fetchValid && execIsLoad && execBypass.rd != '0 &&
                         (execBypass.rd == rs1 || (usesRs2 && execBypass.rd == rs2));

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (writeback.regWrite && writeback.rd != '0) begin
         regs[writeback.rd] <= writeback.value;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         decoded <= '0;
      end else if (!hold) begin
         if (flush || loadUseStall) begin
            decoded <= '0;
         end else begin
            decoded <= decodedNext;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire logic               hold,
   input  wire coreTypes::decodedT decoded,
   output coreTypes::writebackT    execBypass,
   output logic                    execIsLoad,
   output logic                    redirectValid,
   output coreTypes::addrT         redirect,
   output coreTypes::execResultT   execResult
);
   import coreTypes::*;

   wordT aluResult;
   logic operandsEqual;

   always_comb begin
      case (decoded.aluOp)
         opAdd:   aluResult = decoded.a + decoded.b;
         opSub:   aluResult = decoded.a - decoded.b;
         opAnd:   aluResult = decoded.a & decoded.b;
         opOr:    aluResult = decoded.a | decoded.b;
         opXor:   aluResult = decoded.a ^ decoded.b;
         opPass:  aluResult = decoded.b;
         default: aluResult = decoded.b;
      endcase
   end

   assign operandsEqual = (decoded.a == decoded.b);

   // BEQ when equal, BNE when not
   assign redirectValid = decoded.valid && decoded.isBranch &&
                          (operandsEqual == decoded.branchOnEqual);
   assign redirect      = decoded.branchTarget;

   assign execBypass.regWrite = decoded.valid && decoded.regWrite;
   assign execBypass.rd       = decoded.rd;
   assign execBypass.value    = aluResult;
   assign execIsLoad          = decoded.valid && decoded.memRead;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         execResult <= '0;
      end else if (!hold) begin
         execResult.pc        <= decoded.pc;
         execResult.result    <= aluResult;
         execResult.storeData <= decoded.storeData;
         execResult.rd        <= decoded.rd;
         execResult.regWrite  <= decoded.regWrite;
         execResult.memRead   <= decoded.memRead;
         execResult.memWrite  <= decoded.memWrite;
         execResult.valid     <= decoded.valid;
      end
   end

endmodule

`default_nettype wire

//--- logic/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
   parameter coreTypes::addrT resetPc = '0
) (
   input  wire logic            clk,
   input  wire logic            rstN,
   input  wire logic            hold,
   input  wire logic            redirectValid,
   input  wire coreTypes::addrT redirect,
   input  wire coreTypes::instrT instrData,
   output coreTypes::addrT      instrAddr,
   output coreTypes::addrT      fetchPc,
   output coreTypes::instrT     fetchInstr,
   output logic                 fetchValid
);
   import coreTypes::*;

   addrT pc;

   // Instruction memory answers in the same cycle
   assign instrAddr = pc;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc         <= resetPc;
         fetchPc    <= '0;
         fetchInstr <= '0;
         fetchValid <= 1'b0;
      end else if (!hold) begin
         if (redirectValid) begin
            // Wrong-path instruction is dropped here
            pc         <= redirect;
            fetchValid <= 1'b0;
         end else begin
            pc         <= pc + 32'd4;
            fetchPc    <= pc;
            fetchInstr <= instrData;
            fetchValid <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
   input  wire logic                  clk,
   input  wire logic                  rstN,
   input  wire coreTypes::execResultT execResult,
   input  wire logic                  wbAck,
   input  wire coreTypes::wordT       wbDatRd,
   output logic                       memBusy,
   output logic                       wbCyc,
   output logic                       wbStb,
   output logic                       wbWe,
   output coreTypes::addrT            wbAdr,
   output coreTypes::wordT            wbDatWr,
   output coreTypes::writebackT       writeback,
   output coreTypes::retireT          retire
);
   import coreTypes::*;

   logic memRequest;
   logic ackLast;
   logic transferDone;
   logic complete;

   assign memRequest = execResult.valid && (execResult.memRead || execResult.memWrite);

   // Bus stays idle for one cycle after every ack
   assign wbCyc   = memRequest && !ackLast;
   assign wbStb   = wbCyc;
   assign wbWe    = execResult.memWrite;
   assign wbAdr   = execResult.result;
   assign wbDatWr = execResult.storeData;

   assign transferDone = wbStb && wbAck;
   assign memBusy      = memRequest && !transferDone;
   assign complete     = execResult.valid && !memBusy;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ackLast <= 1'b0;
      end else begin
         ackLast <= transferDone;
      end
   end

   // Into the register file at the end of this cycle
   assign writeback.regWrite = complete && execResult.regWrite;
   assign writeback.rd       = execResult.rd;
   assign writeback.value    = execResult.memRead ? wbDatRd : execResult.result;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         retire <= '0;
      end else begin
         retire.valid      <= complete;
         retire.pc         <= execResult.pc;
         retire.regWrite   <= execResult.regWrite;
         retire.rd         <= execResult.rd;
         retire.writeValue <= writeback.value;
         retire.memRead    <= execResult.memRead;
         retire.memWrite   <= execResult.memWrite;
         retire.memAddress <= execResult.result;
         if (execResult.memWrite) begin
            retire.memData <= execResult.storeData;
         end else if (execResult.memRead) begin
            retire.memData <= wbDatRd;
         end else begin
            retire.memData <= '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/procHier.sv
`timescale 1ns/1ps
`default_nettype none

module procHier #(
   parameter coreTypes::addrT resetPc = '0
) (
   input  wire logic             clk,
   input  wire logic             rstN,
   input  wire coreTypes::instrT instrData,
   input  wire logic             wbAck,
   input  wire coreTypes::wordT  wbDatRd,
   output coreTypes::addrT       instrAddr,
   output logic                  wbCyc,
   output logic                  wbStb,
   output logic                  wbWe,
   output coreTypes::addrT       wbAdr,
   output coreTypes::wordT       wbDatWr,
   output coreTypes::retireT     retire
);
   import coreTypes::*;

   addrT       fetchPc;
   instrT      fetchInstr;
   logic       fetchValid;
   decodedT    decoded;
   execResultT execResult;
   writebackT  execBypass;
   writebackT  writeback;
   logic       execIsLoad;
   logic       redirectValid;
   addrT       redirect;
   logic       memBusy;
   logic       loadUseStall;

   fetchStage #(
      .resetPc(resetPc)
   ) fetch (
      .clk          (clk),
      .rstN         (rstN),
      .hold         (memBusy || loadUseStall),
      .redirectValid(redirectValid),
      .redirect     (redirect),
      .instrData    (instrData),
      .instrAddr    (instrAddr),
      .fetchPc      (fetchPc),
      .fetchInstr   (fetchInstr),
      .fetchValid   (fetchValid)
   );

   // Load-use stall sends a bubble forward rather than holding execute
   decodeStage decode (
      .clk         (clk),
      .rstN        (rstN),
      .hold        (memBusy),
      .flush       (redirectValid),
      .fetchPc     (fetchPc),
      .fetchInstr  (fetchInstr),
      .fetchValid  (fetchValid),
      .execBypass  (execBypass),
      .execIsLoad  (execIsLoad),
      .writeback   (writeback),
      .loadUseStall(loadUseStall),
      .decoded     (decoded)
   );

   executeStage execute (
      .clk          (clk),
      .rstN         (rstN),
      .hold         (memBusy),
      .decoded      (decoded),
      .execBypass   (execBypass),
      .execIsLoad   (execIsLoad),
      .redirectValid(redirectValid),
      .redirect     (redirect),
      .execResult   (execResult)
   );

   memoryStage memory (
      .clk       (clk),
      .rstN      (rstN),
      .execResult(execResult),
      .wbAck     (wbAck),
      .wbDatRd   (wbDatRd),
      .memBusy   (memBusy),
      .wbCyc     (wbCyc),
      .wbStb     (wbStb),
      .wbWe      (wbWe),
      .wbAdr     (wbAdr),
      .wbDatWr   (wbDatWr),
      .writeback (writeback),
      .retire    (retire)
   );

endmodule

`default_nettype wire

//--- tb.f
logic/coreTypes.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/procHier.sv
test/procHierBench.sv

//--- test/procHierBench.sv
`timescale 1ns/1ps
`default_nettype none

module procHierBench;
   import coreTypes::*;

   localparam addrT  bootPc      = 32'h0000_0000;
   localparam int    programSize = 96;
   localparam int    dataWords   = 64;
   localparam int    idleLimit   = 200;
   localparam int    runCap      = 20000;
   localparam instrT nopWord     = 32'h0000_0013;
   localparam addrT  haltPc      = bootPc + 32'(4 * (programSize - 1));

   typedef enum logic [3:0] {
      kindAdd, kindSub, kindAnd, kindOr, kindXor, kindAddi,
      kindLoad, kindStore, kindBeq, kindBne, kindNop
   } kindT;

   logic   clk;
   logic   rstN;
   instrT  instrData;
   logic   wbAck;
   wordT   wbDatRd;
   addrT   instrAddr;
   logic   wbCyc;
   logic   wbStb;
   logic   wbWe;
   addrT   wbAdr;
   wordT   wbDatWr;
   retireT retire;

   // Program image and what each entry means to the model
   instrT  progWords [programSize];
   kindT   progKind [programSize];
   regIdxT progRd [programSize];
   regIdxT progRs1 [programSize];
   regIdxT progRs2 [programSize];
   wordT   progImm [programSize];

   wordT   dataMem [dataWords];
   wordT   modelMem [dataWords];
   wordT   modelRegs [8];
   addrT   modelPc;
   logic   halted;
   logic   retiredNow;

   // Wishbone slave and monitor state
   int     busWaits;
   logic   busArmed;
   logic   prevStb;
   logic   prevAck;
   logic   prevWe;
   addrT   prevAdr;
   wordT   prevDat;

   procHier #(
      .resetPc(bootPc)
   ) i_dut (
      .clk      (clk),
      .rstN     (rstN),
      .instrData(instrData),
      .wbAck    (wbAck),
      .wbDatRd  (wbDatRd),
      .instrAddr(instrAddr),
      .wbCyc    (wbCyc),
      .wbStb    (wbStb),
      .wbWe     (wbWe),
      .wbAdr    (wbAdr),
      .wbDatWr  (wbDatWr),
      .retire   (retire)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stopWithFailure(input string reason);
      $display("%s", reason);
      $display("test failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic compareWord(input string name, input wordT got, input wordT expected);
      if (got !== expected) begin
         stopWithFailure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, expected));
      end
   endtask

   task automatic compareAddr(input string name, input addrT got, input addrT expected);
      if (got !== expected) begin
         stopWithFailure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, expected));
      end
   endtask

   task automatic compareIdx(input string name, input regIdxT got, input regIdxT expected);
      if (got !== expected) begin
         stopWithFailure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, expected));
      end
   endtask

   task automatic compareFlag(input string name, input logic got, input logic expected);
      if (got !== expected) begin
         stopWithFailure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, expected));
      end
   endtask

   function automatic regIdxT pickRegister();
      return regIdxT'($urandom % 8);
   endfunction

   function automatic wordT signExtend12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic kindT kindForPick(input int pick);
      case (pick)
         0:       return kindAdd;
         1:       return kindSub;
         2:       return kindAnd;
         3:       return kindOr;
         4:       return kindXor;
         5, 6, 7: return kindAddi;
         8, 9:    return kindLoad;
         10, 11:  return kindStore;
         12:      return kindBeq;
         13:      return kindBne;
         14:      return kindNop;
         default: return kindAddi;
      endcase
   endfunction

   // RV32I field layouts with register numbers padded to five bits
   task automatic placeInstr(input int idx, input kindT kind, input regIdxT rd,
                             input regIdxT rs1, input regIdxT rs2, input wordT imm);
      instrT word;
      case (kind)
         kindAdd: word = {7'h00, 2'b00, rs2, 2'b00, rs1, 3'b000, 2'b00, rd, 7'b0110011};
         kindSub: word = {7'h20, 2'b00, rs2, 2'b00, rs1, 3'b000, 2'b00, rd, 7'b0110011};
         kindAnd: word = {7'h00, 2'b00, rs2, 2'b00, rs1, 3'b111, 2'b00, rd, 7'b0110011};
         kindOr:  word = {7'h00, 2'b00, rs2, 2'b00, rs1, 3'b110, 2'b00, rd, 7'b0110011};
         kindXor: word = {7'h00, 2'b00, rs2, 2'b00, rs1, 3'b100, 2'b00, rd, 7'b0110011};
         kindAddi: word = {imm[11:0], 2'b00, rs1, 3'b000, 2'b00, rd, 7'b0010011};
         kindLoad: word = {imm[11:0], 2'b00, rs1, 3'b010, 2'b00, rd, 7'b0000011};
         kindStore: word = {imm[11:5], 2'b00, rs2, 2'b00, rs1, 3'b010, imm[4:0], 7'b0100011};
         kindBeq: word = {imm[12], imm[10:5], 2'b00, rs2, 2'b00, rs1, 3'b000,
                          imm[4:1], imm[11], 7'b1100011};
         kindBne: word = {imm[12], imm[10:5], 2'b00, rs2, 2'b00, rs1, 3'b001,
                          imm[4:1], imm[11], 7'b1100011};
         // LUI is outside the subset
         default: word = {imm[19:0], 2'b00, rd, 7'b0110111};
      endcase
      progWords[idx] = word;
      progKind[idx]  = kind;
      progRd[idx]    = rd;
      progRs1[idx]   = rs1;
      progRs2[idx]   = rs2;
      progImm[idx]   = imm;
   endtask

   task automatic buildProgram();
      kindT   kind;
      regIdxT rd;
      regIdxT rs1;
      regIdxT rs2;
      regIdxT loadRd;
      logic   chainUse;
      int     step;
      chainUse = 1'b0;
      loadRd   = '0;
      // Give x1..x7 known values first
      for (int i = 0; i < 7; i++) begin
         placeInstr(i, kindAddi, regIdxT'(i + 1), '0, '0, signExtend12(12'($urandom)));
      end
      for (int i = 7; i < programSize - 1; i++) begin
         rd  = pickRegister();
         rs1 = pickRegister();
         rs2 = pickRegister();
         if (chainUse) begin
            kind = kindForPick(int'($urandom % 5));
            if ($urandom % 2 == 0) begin
               rs1 = loadRd;
            end else begin
               rs2 = loadRd;
            end
            placeInstr(i, kind, rd, rs1, rs2, '0);
            chainUse = 1'b0;
         end else begin
            kind = kindForPick(int'($urandom % 16));
            case (kind)
               kindLoad: begin
                  placeInstr(i, kind, rd, '0, rs2, wordT'(4 * int'($urandom % 64)));
                  loadRd   = rd;
                  chainUse = ($urandom % 2 == 0);
               end
               kindStore: placeInstr(i, kind, rd, '0, rs2, wordT'(4 * int'($urandom % 64)));
               kindBeq, kindBne: begin
                  // Forward only and never past the halt
                  step = 1 + int'($urandom % 4);
                  if (i + step > programSize - 1) begin
                     step = programSize - 1 - i;
                  end
                  placeInstr(i, kind, rd, rs1, rs2, wordT'(4 * step));
               end
               kindAddi: placeInstr(i, kind, rd, rs1, rs2, signExtend12(12'($urandom)));
               kindNop: placeInstr(i, kind, rd, rs1, rs2, $urandom);
               default: placeInstr(i, kind, rd, rs1, rs2, '0);
            endcase
         end
      end
      placeInstr(programSize - 1, kindBeq, '0, '0, '0, '0);
   endtask

   task automatic answerFetch();
      addrT offset;
      offset = instrAddr - bootPc;
      if (offset < programSize * 4 && offset[1:0] == 2'b00) begin
         instrData = progWords[int'(offset >> 2)];
      end else begin
         instrData = nopWord;
      end
   endtask

   task automatic checkBus();
      compareFlag("wbStb", wbStb, wbCyc);
      if (prevStb && !prevAck) begin
         compareFlag("wbStb", wbStb, 1'b1);
         compareAddr("wbAdr", wbAdr, prevAdr);
         compareFlag("wbWe", wbWe, prevWe);
         if (prevWe) begin
            compareWord("wbDatWr", wbDatWr, prevDat);
         end
      end
      if (prevStb && prevAck) begin
         compareFlag("wbCyc", wbCyc, 1'b0);
      end
   endtask

   // Slave with 0 to 3 wait states per transfer
   task automatic answerBus();
      if (wbStb && !wbAck) begin
         if (!busArmed) begin
            busArmed = 1'b1;
            busWaits = int'($urandom % 4);
         end
         if (busWaits == 0) begin
            if (wbAdr[31:8] != '0 || wbAdr[1:0] != 2'b00) begin
               stopWithFailure($sformatf("data access outside the data array at 0x%h", wbAdr));
            end
            wbAck = 1'b1;
            if (wbWe) begin
               dataMem[wbAdr[7:2]] = wbDatWr;
            end else begin
               wbDatRd = dataMem[wbAdr[7:2]];
            end
            busArmed = 1'b0;
         end else begin
            busWaits--;
         end
      end else begin
         wbAck   = 1'b0;
         wbDatRd = $urandom;
      end
      prevStb = wbStb;
      prevAck = wbAck;
      prevWe  = wbWe;
      prevAdr = wbAdr;
      prevDat = wbDatWr;
   endtask

   // Instruction-set model steps once per retired instruction
   task automatic checkRetire();
      kindT kind;
      int   idx;
      wordT a;
      wordT b;
      wordT value;
      addrT addr;
      logic writes;
      logic taken;
      compareAddr("retire.pc", retire.pc, modelPc);
      idx    = int'((modelPc - bootPc) >> 2);
      kind   = progKind[idx];
      a      = modelRegs[progRs1[idx]];
      b      = modelRegs[progRs2[idx]];
      addr   = a + progImm[idx];
      value  = '0;
      taken  = 1'b0;
      case (kind)
         kindAdd: value = a + b;
         kindSub: value = a - b;
         kindAnd: value = a & b;
         kindOr:  value = a | b;
         kindXor: value = a ^ b;
         kindAddi: value = addr;
         kindLoad: value = modelMem[addr[7:2]];
         kindBeq: taken = (a == b);
         kindBne: taken = (a != b);
         default: value = '0;
      endcase
      writes = (kind inside {kindAdd, kindSub, kindAnd, kindOr, kindXor, kindAddi, kindLoad});
      compareFlag("retire.regWrite", retire.regWrite, writes);
      compareFlag("retire.memRead", retire.memRead, kind == kindLoad);
      compareFlag("retire.memWrite", retire.memWrite, kind == kindStore);
      if (writes) begin
         compareIdx("retire.rd", retire.rd, progRd[idx]);
         compareWord("retire.writeValue", retire.writeValue, value);
         if (progRd[idx] != '0) begin
            modelRegs[progRd[idx]] = value;
         end
      end
      if (kind == kindLoad) begin
         compareAddr("retire.memAddress", retire.memAddress, addr);
         compareWord("retire.memData", retire.memData, value);
      end
      if (kind == kindStore) begin
         compareAddr("retire.memAddress", retire.memAddress, addr);
         compareWord("retire.memData", retire.memData, b);
         modelMem[addr[7:2]] = b;
      end
      if (modelPc == haltPc) begin
         halted = 1'b1;
      end
      modelPc = taken ? modelPc + progImm[idx] : modelPc + 32'd4;
   endtask

   task automatic stepCycle();
      @(negedge clk);
      retiredNow = retire.valid;
      checkBus();
      if (retire.valid) begin
         checkRetire();
      end
      answerFetch();
      answerBus();
   endtask

   initial begin
      int cycles;
      int idle;
      void'($urandom(32'he5d9b619));
      rstN       = 1'b0;
      instrData  = nopWord;
      wbAck      = 1'b0;
      wbDatRd    = '0;
      busWaits   = 0;
      busArmed   = 1'b0;
      prevStb    = 1'b0;
      prevAck    = 1'b0;
      prevWe     = 1'b0;
      prevAdr    = '0;
      prevDat    = '0;
      halted     = 1'b0;
      retiredNow = 1'b0;
      modelPc    = bootPc;
      for (int r = 0; r < 8; r++) begin
         modelRegs[r] = '0;
      end
      buildProgram();
      for (int w = 0; w < dataWords; w++) begin
         dataMem[w]  = $urandom;
         modelMem[w] = dataMem[w];
      end

      repeat (2) begin
         @(negedge clk);
         compareFlag("wbCyc", wbCyc, 1'b0);
         compareFlag("wbStb", wbStb, 1'b0);
         compareFlag("retire.valid", retire.valid, 1'b0);
      end
      rstN = 1'b1;
      compareAddr("instrAddr", instrAddr, bootPc);
      answerFetch();

      cycles = 0;
      idle   = 0;
      while (!halted) begin
         stepCycle();
         cycles++;
         idle = retiredNow ? 0 : idle + 1;
         if (idle >= idleLimit) begin
            stopWithFailure("no instruction retired for 200 cycles");
         end
         if (cycles >= runCap) begin
            stopWithFailure("the halt branch did not retire within the overall cycle cap");
         end
      end

      // Data memory must match the model after the halt
      for (int w = 0; w < dataWords; w++) begin
         compareWord($sformatf("dataMem[%0d]", w), dataMem[w], modelMem[w]);
      end
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire
